/* Makefile */
# verilator build and run of the jtag bridge testbench

TOP := tb_jtag_wb_bridge

.PHONY: help test clean

help:
	@echo "make test   build the testbench with verilator and run it"
	@echo "make clean  remove the verilator build directory"
	@echo "make help   show this list"

# a failing run ends in \$fatal, which makes the simulator exit non-zero
test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f build.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* build.f */
+incdir+verification
design/jtag_bridge_pkg.sv
design/dr_chain.sv
design/bus_sequencer.sv
design/target_select.sv
design/jtag_wb_bridge.sv
verification/tb_jtag_wb_bridge.sv

/* design/bus_sequencer.sv */
// bus request sequencer
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer (
    input  logic                   tclk,
    input  logic                   reset,
    input  jtag_bridge_pkg::ir_t   ir,
    input  jtag_bridge_pkg::data_t payload,
    input  logic                   addr_load,
    input  logic                   write_req,
    input  logic                   read_req,
    input  logic                   req_ack,
    output logic                   req_stb,
    output logic                   req_we,
    output jtag_bridge_pkg::addr_t bus_addr,
    output jtag_bridge_pkg::data_t bus_wdata
);

    import jtag_bridge_pkg::*;

    bus_state_t state;
    bus_state_t state_next;
    logic       addr_inc;

    // strobe follows the state and drops the cycle after ack
    assign req_stb = (state == st_write) || (state == st_read);
    assign req_we  = (state == st_write);

    // control register writes leave the address alone
    assign addr_inc = (state == st_write) && req_ack && (ir == ir_wr_data);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (write_req) begin
                    state_next = st_write;
                end else if (read_req) begin
                    state_next = st_read;
                end
            end
            st_write,
            st_read: begin
                if (req_ack) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge tclk or posedge reset) begin
        if (reset) begin
            state    <= st_idle;
            bus_addr <= '0;
        end else begin
            state <= state_next;
            if (state == st_idle && addr_load) begin
                bus_addr <= addr_t'(payload);
            end else if (addr_inc) begin
                bus_addr <= bus_addr + 1'b1;
            end
        end
    end

    // write data held for the whole request
    always_ff @(posedge tclk) begin
        if (state == st_idle && write_req) begin
            bus_wdata <= payload;
        end
    end

    // an ack only ever closes an open request
    a_ack_in_req: assert property (
        @(posedge tclk) disable iff (reset) req_ack |-> req_stb
    ) else $error("req_ack without an open request");

    // strobe and address hold until ack
    a_stb_held: assert property (
        @(posedge tclk) disable iff (reset)
        (req_stb && !req_ack) |=> (req_stb && $stable(bus_addr))
    ) else $error("req_stb or bus_addr changed before ack");

endmodule

`default_nettype wire

/* design/dr_chain.sv */
// jtag data register chain
`timescale 1ns/1ps
`default_nettype none

module dr_chain (
    input  logic                     tclk,
    input  logic                     reset,
    input  logic                     tdi,
    input  logic                     capture_dr,
    input  logic                     shift_dr,
    input  logic                     update_dr,
    input  jtag_bridge_pkg::data_t   rd_data,
    input  jtag_bridge_pkg::status_t sel_status,
    output logic                     tdo,
    output jtag_bridge_pkg::index_t  index,
    output jtag_bridge_pkg::ir_t     ir,
    output jtag_bridge_pkg::data_t   payload,
    output logic                     addr_load,
    output logic                     write_req,
    output logic                     read_req
);

    import jtag_bridge_pkg::*;

    logic [frame_width-1:0] shift_buf;
    logic                   mask;      // blocks reads until fresh data arrives

    logic update_index;
    logic update_ir;
    logic update_data;

    assign tdo = shift_buf[0];  // lsb leaves first

    // flags of the frame currently sitting in the buffer
    assign update_index = shift_buf[flag_index_bit];
    assign update_ir    = shift_buf[flag_ir_bit];
    assign update_data  = shift_buf[flag_data_bit];

    // shift and capture
    always_ff @(posedge tclk or posedge reset) begin
        if (reset) begin
            shift_buf <= '0;
        end else if (shift_dr) begin
            shift_buf <= {tdi, shift_buf[frame_width-1:1]};
        end else if (capture_dr) begin
            case (ir)
                ir_rd_data:   shift_buf[$bits(data_t)-1:0] <= rd_data;
                ir_rd_status: shift_buf[$bits(status_t)-1:0] <= sel_status;
                default:      ;  // buffer keeps what was shifted in
            endcase
        end
    end

    // index, instruction and mask
    always_ff @(posedge tclk or posedge reset) begin
        if (reset) begin
            index <= '0;
            ir    <= ir_bypass;
            mask  <= 1'b1;
        end else if (update_dr) begin
            if (update_index) begin
                index <= shift_buf[$bits(index_t)-1:0];
                ir    <= ir_bypass;  // new target starts from a clean instruction
                mask  <= 1'b1;
            end else if (update_ir) begin
                ir    <= ir_t'(shift_buf[$bits(ir_t)-1:0]);
                mask  <= 1'b1;
            end
            if (update_data) begin
                mask <= 1'b0;
            end
        end
    end

    // payload word
    always_ff @(posedge tclk) begin
        if (update_dr && update_data) begin
            payload <= shift_buf[$bits(data_t)-1:0];
        end
    end

    // request pulses, decoded against the instruction in force before the update
    always_ff @(posedge tclk or posedge reset) begin
        if (reset) begin
            addr_load <= 1'b0;
            write_req <= 1'b0;
            read_req  <= 1'b0;
        end else begin
            addr_load <= update_dr && update_data &&
                         (ir == ir_wr_addr || ir == ir_rd_data);
            write_req <= update_dr && update_data &&
                         (ir == ir_wr_data || ir == ir_update_ctrl);
            read_req  <= capture_dr && (ir == ir_rd_data) && !mask;
        end
    end

    // the tap never shifts and updates in one cycle
    a_no_shift_update: assert property (
        @(posedge tclk) disable iff (reset) !(shift_dr && update_dr)
    ) else $error("shift_dr and update_dr high together");

endmodule

`default_nettype wire

/* design/jtag_bridge_pkg.sv */
// jtag bridge shared definitions
`default_nettype none

package jtag_bridge_pkg;

    // basic widths
    localparam int data_width   = 32;
    localparam int addr_width   = 32;
    localparam int index_width  = 8;
    localparam int status_width = 8;
    localparam int ir_width     = 3;

    typedef logic [data_width-1:0]   data_t;    // bus and payload data
    typedef logic [addr_width-1:0]   addr_t;    // bus address
    typedef logic [index_width-1:0]  index_t;   // target index
    typedef logic [status_width-1:0] status_t;  // target status byte

    // instruction codes held in the ir register
    typedef enum logic [ir_width-1:0] {
        ir_bypass      = 3'd0,
        ir_update_ctrl = 3'd1,
        ir_rd_status   = 3'd4,
        ir_rd_data     = 3'd5,
        ir_wr_data     = 3'd6,
        ir_wr_addr     = 3'd7
    } ir_t;

    // bus sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_read
    } bus_state_t;

    // bus targets
    localparam int     num_targets       = 2;
    localparam index_t target_base_index = 8'd1;  // target i sits at base + i
    localparam index_t ctrl_index        = 8'd127;

    // frame layout, payload in bits 31:0, update flags above it
    localparam int frame_width    = 36;
    localparam int flag_index_bit = 32;
    localparam int flag_ir_bit    = 33;
    localparam int flag_data_bit  = 34;

endpackage

`default_nettype wire

/* design/jtag_wb_bridge.sv */
// jtag to memory bus bridge top
`timescale 1ns/1ps
`default_nettype none

module jtag_wb_bridge (
    input  logic                     tclk,
    input  logic                     reset,
    // tap side, already gated by the user select
    input  logic                     tdi,
    input  logic                     capture_dr,
    input  logic                     shift_dr,
    input  logic                     update_dr,
    output logic                     tdo,
    // bus side
    output jtag_bridge_pkg::addr_t   bus_addr,
    output jtag_bridge_pkg::data_t   bus_wdata,
    output logic                     bus_we,
    output logic                     [jtag_bridge_pkg::num_targets-1:0] bus_stb,
    input  jtag_bridge_pkg::data_t   [jtag_bridge_pkg::num_targets-1:0] bus_rdata,
    input  logic                     [jtag_bridge_pkg::num_targets-1:0] bus_ack,
    input  jtag_bridge_pkg::status_t [jtag_bridge_pkg::num_targets-1:0] bus_status,
    // system control
    output logic                     system_reset,
    output logic                     cpu_en
);

    import jtag_bridge_pkg::*;

    index_t  index;
    ir_t     ir;
    data_t   payload;
    logic    addr_load;
    logic    write_req;
    logic    read_req;
    logic    req_stb;
    logic    req_ack;
    data_t   rd_data;
    status_t sel_status;

    dr_chain u_dr_chain (
        .tclk       (tclk),
        .reset      (reset),
        .tdi        (tdi),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .rd_data    (rd_data),
        .sel_status (sel_status),
        .tdo        (tdo),
        .index      (index),
        .ir         (ir),
        .payload    (payload),
        .addr_load  (addr_load),
        .write_req  (write_req),
        .read_req   (read_req)
    );

    bus_sequencer u_bus_sequencer (
        .tclk      (tclk),
        .reset     (reset),
        .ir        (ir),
        .payload   (payload),
        .addr_load (addr_load),
        .write_req (write_req),
        .read_req  (read_req),
        .req_ack   (req_ack),
        .req_stb   (req_stb),
        .req_we    (bus_we),   // shared we, also steers the read latches
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata)
    );

    target_select u_target_select (
        .tclk         (tclk),
        .reset        (reset),
        .index        (index),
        .req_stb      (req_stb),
        .req_we       (bus_we),
        .payload      (payload),
        .bus_rdata    (bus_rdata),
        .bus_ack      (bus_ack),
        .bus_status   (bus_status),
        .bus_stb      (bus_stb),
        .req_ack      (req_ack),
        .rd_data      (rd_data),
        .sel_status   (sel_status),
        .system_reset (system_reset),
        .cpu_en       (cpu_en)
    );

endmodule

`default_nettype wire

/* design/target_select.sv */
// bus target selection and control register
`timescale 1ns/1ps
`default_nettype none

module target_select (
    input  logic                     tclk,
    input  logic                     reset,
    input  jtag_bridge_pkg::index_t  index,
    input  logic                     req_stb,
    input  logic                     req_we,
    input  jtag_bridge_pkg::data_t   payload,
    input  jtag_bridge_pkg::data_t   [jtag_bridge_pkg::num_targets-1:0] bus_rdata,
    input  logic                     [jtag_bridge_pkg::num_targets-1:0] bus_ack,
    input  jtag_bridge_pkg::status_t [jtag_bridge_pkg::num_targets-1:0] bus_status,
    output logic                     [jtag_bridge_pkg::num_targets-1:0] bus_stb,
    output logic                     req_ack,
    output jtag_bridge_pkg::data_t   rd_data,
    output jtag_bridge_pkg::status_t sel_status,
    output logic                     system_reset,
    output logic                     cpu_en
);

    import jtag_bridge_pkg::*;

    logic [num_targets-1:0] sel_onehot;
    logic                   internal_sel;  // control register or no target
    logic                   int_ack;
    logic [1:0]             ctrl_reg;
    data_t                  rd_latch [num_targets];

    // one compare per target, indexes are fixed and distinct
    always_comb begin
        for (int i = 0; i < num_targets; i++) begin
            sel_onehot[i] = (index == index_t'(target_base_index + i));
        end
    end

    assign internal_sel = (index == ctrl_index) || (sel_onehot == '0);
    assign bus_stb      = sel_onehot & {num_targets{req_stb}};
    assign req_ack      = internal_sel ? int_ack : |(bus_ack & sel_onehot);

    // single cycle ack for requests that never reach the bus
    always_ff @(posedge tclk or posedge reset) begin
        if (reset) begin
            int_ack <= 1'b0;
        end else begin
            int_ack <= req_stb && internal_sel && !int_ack;
        end
    end

    // read data kept per target until the next read
    always_ff @(posedge tclk) begin
        for (int i = 0; i < num_targets; i++) begin
            if (bus_stb[i] && bus_ack[i] && !req_we) begin
                rd_latch[i] <= bus_rdata[i];
            end
        end
    end

    // one-hot muxes, zero when nothing matches
    always_comb begin
        rd_data    = '0;
        sel_status = '0;
        for (int i = 0; i < num_targets; i++) begin
            rd_data    = rd_data | (rd_latch[i] & {$bits(data_t){sel_onehot[i]}});
            sel_status = sel_status | (bus_status[i] & {$bits(status_t){sel_onehot[i]}});
        end
    end

    // control register at ctrl_index
    always_ff @(posedge tclk or posedge reset) begin
        if (reset) begin
            ctrl_reg     <= 2'b00;
            system_reset <= 1'b0;
            cpu_en       <= 1'b1;
        end else begin
            if (req_stb && req_we && index == ctrl_index) begin
                ctrl_reg <= payload[1:0];
            end
            system_reset <= ctrl_reg[0];
            cpu_en       <= ~ctrl_reg[1];  // bit 1 halts the cpu
        end
    end

    a_stb_onehot: assert property (
        @(posedge tclk) disable iff (reset) $onehot0(bus_stb)
    ) else $error("more than one bus_stb high");

endmodule

`default_nettype wire

/* verification/jtag_host_tasks.svh */
// jtag host frame tasks
`ifndef jtag_host_tasks_svh
`define jtag_host_tasks_svh

// galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(inout logic [31:0] state, input int count);
    logic [31:0] value;
    value = '0;
    for (int k = 0; k < count; k++) begin
        state = lfsr_step(state);
        value = {value[30:0], state[0]};
    end
    return value;
endfunction

// lsb first, old buffer contents come back on tdo
task automatic shift_frame(input logic [frame_width-1:0] frame_in,
                           output logic [frame_width-1:0] frame_out);
    for (int k = 0; k < frame_width; k++) begin
        @(negedge tclk);
        frame_out[k] = tdo;
        shift_dr     = 1'b1;
        tdi          = frame_in[k];
    end
    @(negedge tclk);
    shift_dr = 1'b0;
    tdi      = 1'b0;
endtask

task automatic pulse_update();
    @(negedge tclk);
    update_dr = 1'b1;
    @(negedge tclk);
    update_dr = 1'b0;
endtask

task automatic send_frame(input logic [frame_width-1:0] frame);
    logic [frame_width-1:0] discard;
    shift_frame(frame, discard);
    pulse_update();
endtask

task automatic send_index(input index_t value);
    logic [frame_width-1:0] frame;
    frame                     = '0;
    frame[flag_index_bit]     = 1'b1;
    frame[$bits(index_t)-1:0] = value;
    send_frame(frame);
endtask

task automatic send_ir(input ir_t value);
    logic [frame_width-1:0] frame;
    frame                  = '0;
    frame[flag_ir_bit]     = 1'b1;
    frame[$bits(ir_t)-1:0] = value;
    send_frame(frame);
endtask

task automatic send_data(input data_t value);
    logic [frame_width-1:0] frame;
    frame                    = '0;
    frame[flag_data_bit]     = 1'b1;
    frame[$bits(data_t)-1:0] = value;
    send_frame(frame);
endtask

// capture, optionally let the started bus read finish, then shift the word out
task automatic capture_word(input logic with_xfer, output data_t word);
    logic [frame_width-1:0] frame_out;
    @(negedge tclk);
    capture_dr = 1'b1;
    @(negedge tclk);
    capture_dr = 1'b0;
    if (with_xfer) begin
        wait_transfer();
    end
    shift_frame('0, frame_out);
    word = frame_out[$bits(data_t)-1:0];
endtask

`endif

/* verification/tb_jtag_wb_bridge.sv */
// jtag bridge testbench
`timescale 1ns/1ps
`default_nettype none

module tb_jtag_wb_bridge;

    import jtag_bridge_pkg::*;

    localparam int mem_words  = 16;
    localparam int xfer_limit = 40;  // cycles per transfer phase

    logic                      tclk = 1'b0;
    logic                      reset;
    logic                      tdi;
    logic                      capture_dr;
    logic                      shift_dr;
    logic                      update_dr;
    logic                      tdo;
    addr_t                     bus_addr;
    data_t                     bus_wdata;
    logic                      bus_we;
    logic [num_targets-1:0]    bus_stb;
    data_t [num_targets-1:0]   bus_rdata;
    logic [num_targets-1:0]    bus_ack;
    status_t [num_targets-1:0] bus_status;
    logic                      system_reset;
    logic                      cpu_en;

    // target memories and the checker's own copy
    data_t       tgt_mem   [num_targets][mem_words];
    data_t       model_mem [num_targets][mem_words];
    logic [31:0] host_lfsr = 32'h590a;
    logic [31:0] tgt_lfsr  = 32'h590a;
    int          ack_delay  [num_targets];
    bit          busy       [num_targets];
    int          xfer_count [num_targets];
    logic        last_we;
    addr_t       last_addr;
    data_t       last_data;
    logic        stb_seen;  // any bus_stb since last clear

    jtag_wb_bridge dut (
        .tclk         (tclk),
        .reset        (reset),
        .tdi          (tdi),
        .capture_dr   (capture_dr),
        .shift_dr     (shift_dr),
        .update_dr    (update_dr),
        .tdo          (tdo),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_we       (bus_we),
        .bus_stb      (bus_stb),
        .bus_rdata    (bus_rdata),
        .bus_ack      (bus_ack),
        .bus_status   (bus_status),
        .system_reset (system_reset),
        .cpu_en       (cpu_en)
    );

    always #5 tclk = ~tclk;

    `include "jtag_host_tasks.svh"

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // waits on the internal strobe so internal acks count too
    task automatic wait_transfer();
        int cycles;
        cycles = 0;
        while (!dut.req_stb) begin
            @(negedge tclk);
            cycles++;
            if (cycles > xfer_limit) begin
                $display("timeout at %0t ns: bus request never started", $time);
                $display("SOME TESTS FAILED");
                $fatal(1, "request timeout");
            end
        end
        cycles = 0;
        while (dut.req_stb) begin
            @(negedge tclk);
            cycles++;
            if (cycles > xfer_limit) begin
                $display("timeout at %0t ns: bus request never acknowledged", $time);
                $display("SOME TESTS FAILED");
                $fatal(1, "acknowledge timeout");
            end
        end
    endtask

    // bus targets that ack after 1 to 4 cycles
    always @(negedge tclk) begin
        if (bus_stb != '0) begin
            stb_seen = 1'b1;
        end
        for (int i = 0; i < num_targets; i++) begin
            if (bus_ack[i]) begin
                bus_ack[i] = 1'b0;  // one cycle only
            end else if (bus_stb[i]) begin
                if (!busy[i]) begin
                    busy[i]      = 1'b1;
                    ack_delay[i] = 1 + int'(rand_bits(tgt_lfsr, 2));
                end
                ack_delay[i]--;
                if (ack_delay[i] == 0) begin
                    busy[i]    = 1'b0;
                    bus_ack[i] = 1'b1;
                    last_we    = bus_we;
                    last_addr  = bus_addr;
                    xfer_count[i]++;
                    if (bus_we) begin
                        last_data                 = bus_wdata;
                        tgt_mem[i][bus_addr[3:0]] = bus_wdata;
                    end else begin
                        bus_rdata[i] = tgt_mem[i][bus_addr[3:0]];
                    end
                end
            end
        end
    end

    initial begin
        data_t      word;
        data_t      wdata;
        addr_t      base;
        int         tgt;
        int         len;
        int         self_count;
        int         other_count;
        index_t     idx;
        logic [1:0] ctrl_bits;

        reset      = 1'b1;
        tdi        = 1'b0;
        capture_dr = 1'b0;
        shift_dr   = 1'b0;
        update_dr  = 1'b0;
        bus_ack    = '0;
        bus_rdata  = '0;
        stb_seen   = 1'b0;
        for (int i = 0; i < num_targets; i++) begin
            bus_status[i] = status_t'(rand_bits(tgt_lfsr, 8));
            busy[i]       = 1'b0;
            xfer_count[i] = 0;
            for (int a = 0; a < mem_words; a++) begin
                tgt_mem[i][a]   = rand_bits(tgt_lfsr, 32);
                model_mem[i][a] = tgt_mem[i][a];
            end
        end
        repeat (5) @(negedge tclk);
        reset = 1'b0;
        @(negedge tclk);

        check_equal("system_reset after reset", 32'(system_reset), 32'd0);
        check_equal("cpu_en after reset", 32'(cpu_en), 32'd1);
        check_equal("bus_stb after reset", 32'(bus_stb), 32'd0);

        // write bursts at incrementing addresses
        repeat (4) begin
            tgt  = int'(rand_bits(host_lfsr, 1));
            base = rand_bits(host_lfsr, 8);
            len  = 2 + int'(rand_bits(host_lfsr, 2));
            send_index(target_base_index + index_t'(tgt));
            send_ir(ir_wr_addr);
            send_data(base);
            send_ir(ir_wr_data);
            for (int k = 0; k < len; k++) begin
                wdata       = rand_bits(host_lfsr, 32);
                self_count  = xfer_count[tgt];
                other_count = xfer_count[num_targets - 1 - tgt];
                send_data(wdata);
                wait_transfer();
                check_equal("writes at target", xfer_count[tgt], self_count + 1);
                check_equal("writes at other target", xfer_count[num_targets - 1 - tgt],
                            other_count);
                check_equal("bus_we on write", 32'(last_we), 32'd1);
                check_equal("write address", last_addr, base + addr_t'(k));
                check_equal("write data", last_data, wdata);
                model_mem[tgt][4'(base + addr_t'(k))] = wdata;
            end
        end

        // reads where the first capture only returns the older latch
        repeat (4) begin
            tgt  = int'(rand_bits(host_lfsr, 1));
            base = rand_bits(host_lfsr, 8);
            send_index(target_base_index + index_t'(tgt));
            send_ir(ir_rd_data);
            send_data(base);
            capture_word(1'b1, word);
            capture_word(1'b1, word);
            check_equal("read data", word, model_mem[tgt][4'(base)]);
            check_equal("read address", last_addr, base);
            check_equal("bus_we on read", 32'(last_we), 32'd0);
        end

        for (int i = 0; i < num_targets; i++) begin
            send_index(target_base_index + index_t'(i));
            send_ir(ir_rd_status);
            capture_word(1'b0, word);
            check_equal("status byte", word, 32'(bus_status[i]));
        end

        // index with no target behind it
        idx      = 8'h40 + index_t'(rand_bits(host_lfsr, 5));
        stb_seen = 1'b0;
        send_index(idx);
        send_ir(ir_rd_status);
        capture_word(1'b0, word);
        check_equal("status of empty index", word, 32'd0);
        send_ir(ir_rd_data);
        send_data(rand_bits(host_lfsr, 8));
        capture_word(1'b1, word);
        capture_word(1'b1, word);
        check_equal("read of empty index", word, 32'd0);
        check_equal("bus_stb for empty index", 32'(stb_seen), 32'd0);

        // control register
        send_index(ctrl_index);
        send_ir(ir_update_ctrl);
        repeat (4) begin
            ctrl_bits  = 2'(rand_bits(host_lfsr, 2));
            wdata      = rand_bits(host_lfsr, 32);
            wdata[1:0] = ctrl_bits;
            stb_seen   = 1'b0;
            send_data(wdata);
            wait_transfer();
            repeat (2) @(negedge tclk);
            check_equal("system_reset", 32'(system_reset), {31'd0, ctrl_bits[0]});
            check_equal("cpu_en", 32'(cpu_en), {31'd0, ~ctrl_bits[1]});
            check_equal("bus_stb for control write", 32'(stb_seen), 32'd0);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
